//--- Makefile
# Verilator build, run and lint for the RV32I decode stage

TOP := tb_rv32i_decode_stage
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard design/*.sv tb/*.sv include/*.svh)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- design/decode_if.sv
// Decoded instruction fields passed from the decoder to the dispatch
// register. The decoder drives the producer side.

`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    import rv32i_pkg::*;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [reg_aw-1:0] rd;
    logic [xlen-1:0]   imm;
    inst_class_t       inst_class;

    modport producer (
        output opcode, funct3, funct7, rs1, rs2, rd, imm, inst_class
    );

    // Source indexes go straight to the register file from the top
    modport consumer (
        input opcode, funct3, funct7, rd, imm, inst_class
    );

endinterface

`resetall

//--- design/rv32i_decode_stage.sv
// Top of the RV32I decode stage. Decoder, register file and dispatch
// register behind plain ports; write-back enters from outside.

`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_stage (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [rv32i_pkg::xlen-1:0]     instr,
    input  logic [rv32i_pkg::xlen-1:0]     instr_pc,
    input  logic                           wb_valid,
    input  logic [rv32i_pkg::reg_aw-1:0]   wb_rd,
    input  logic [rv32i_pkg::xlen-1:0]     wb_data,
    output logic                           dec_valid,
    output logic [rv32i_pkg::xlen-1:0]     dec_pc,
    output rv32i_pkg::inst_class_t         dec_class,
    output logic [6:0]                     dec_opcode,
    output logic [2:0]                     dec_funct3,
    output logic [6:0]                     dec_funct7,
    output logic [rv32i_pkg::reg_aw-1:0]   dec_rd,
    output logic [rv32i_pkg::xlen-1:0]     dec_imm,
    output logic [rv32i_pkg::xlen-1:0]     dec_rs1_val,
    output logic [rv32i_pkg::xlen-1:0]     dec_rs2_val
);

    import rv32i_pkg::*;

    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    decode_if dec_bus ();

    rv32i_decoder u_decoder (
        .instr (instr),
        .dec   (dec_bus.producer)
    );

    // Read ports are addressed straight from the decoded fields
    rv32i_regfile u_regfile (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1      (dec_bus.rs1),
        .rs2      (dec_bus.rs2),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    rv32i_dispatch u_dispatch (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .dec         (dec_bus.consumer),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_class   (dec_class),
        .dec_opcode  (dec_opcode),
        .dec_funct3  (dec_funct3),
        .dec_funct7  (dec_funct7),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_rs1_val (dec_rs1_val),
        .dec_rs2_val (dec_rs2_val)
    );

endmodule

`resetall

//--- design/rv32i_decoder.sv
// Combinational RV32I decoder. Splits the word into fields, picks the
// instruction class and builds the sign-extended immediate.

`timescale 1ns/1ps
`default_nettype none

module rv32i_decoder (
    input  rv32i_pkg::inst_word_t instr,
    decode_if.producer            dec
);

    import rv32i_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // All five immediate formats, each sign-extended from bit 31
    always_comb begin
        imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
        imm_s = {{20{instr.s_fmt.imm_11_5[6]}},
                 instr.s_fmt.imm_11_5,
                 instr.s_fmt.imm_4_0};
        imm_b = {{19{instr.s_fmt.imm_11_5[6]}},
                 instr.s_fmt.imm_11_5[6],
                 instr.s_fmt.imm_4_0[0],
                 instr.s_fmt.imm_11_5[5:0],
                 instr.s_fmt.imm_4_0[4:1],
                 1'b0};
        imm_u = {instr.u_fmt.imm_31_12, 12'b0};
        // J view: word bits 31, 19:12, 20, 30:21
        imm_j = {{11{instr.u_fmt.imm_31_12[19]}},
                 instr.u_fmt.imm_31_12[19],
                 instr.u_fmt.imm_31_12[7:0],
                 instr.u_fmt.imm_31_12[8],
                 instr.u_fmt.imm_31_12[18:9],
                 1'b0};
    end

    always_comb begin
        // Every legal opcode ends in 11, so other low bits fall to default
        case (instr.r_fmt.opcode)
            op_lui: begin
                dec.inst_class = cls_processing;
                dec.imm        = imm_u;
            end
            op_auipc: begin
                dec.inst_class = cls_auipc;
                dec.imm        = imm_u;
            end
            op_jal: begin
                dec.inst_class = cls_jal;
                dec.imm        = imm_j;
            end
            op_jalr: begin
                dec.inst_class = cls_jalr;
                dec.imm        = imm_i;
            end
            op_branch: begin
                dec.inst_class = cls_branching;
                dec.imm        = imm_b;
            end
            op_load,
            op_imm: begin
                dec.inst_class = cls_processing;
                dec.imm        = imm_i;
            end
            op_store: begin
                dec.inst_class = cls_processing;
                dec.imm        = imm_s;
            end
            op_op: begin
                dec.inst_class = cls_processing;
                dec.imm        = '0;
            end
            op_misc_mem: begin
                dec.inst_class = cls_system;
                dec.imm        = '0;
            end
            op_system: begin
                dec.inst_class = cls_system;
                dec.imm        = imm_i;
            end
            default: begin
                dec.inst_class = cls_illegal;
                dec.imm        = '0;
            end
        endcase

        // Fields go out for every word whatever its format
        dec.opcode = instr.r_fmt.opcode;
        dec.funct3 = instr.r_fmt.funct3;
        dec.funct7 = instr.r_fmt.funct7;
        dec.rs1    = instr.r_fmt.rs1;
        dec.rs2    = instr.r_fmt.rs2;
        dec.rd     = instr.r_fmt.rd;
    end

    // Any nonzero immediate carries the sign of word bit 31
    always_comb begin
        if (!$isunknown(instr.raw) && (dec.imm != '0)) begin
            assert final (dec.imm[xlen-1] == instr.raw[31])
                else $error("decoder: immediate sign lost for word %h", instr.raw);
        end
    end

endmodule

`resetall

//--- design/rv32i_dispatch.sv
// Decode packet register. Captures fields, pc and operands on each
// instruction strobe and presents them one clock later.

`timescale 1ns/1ps
`default_nettype none

module rv32i_dispatch (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [rv32i_pkg::xlen-1:0]     instr_pc,
    decode_if.consumer                     dec,
    input  logic [rv32i_pkg::xlen-1:0]     rs1_val,
    input  logic [rv32i_pkg::xlen-1:0]     rs2_val,
    output logic                           dec_valid,
    output logic [rv32i_pkg::xlen-1:0]     dec_pc,
    output rv32i_pkg::inst_class_t         dec_class,
    output logic [6:0]                     dec_opcode,
    output logic [2:0]                     dec_funct3,
    output logic [6:0]                     dec_funct7,
    output logic [rv32i_pkg::reg_aw-1:0]   dec_rd,
    output logic [rv32i_pkg::xlen-1:0]     dec_imm,
    output logic [rv32i_pkg::xlen-1:0]     dec_rs1_val,
    output logic [rv32i_pkg::xlen-1:0]     dec_rs2_val
);

    import rv32i_pkg::*;

    // One packet per strobe, no stall path
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Packet holds until the next strobe
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            dec_pc      <= '0;
            dec_class   <= cls_processing;
            dec_opcode  <= '0;
            dec_funct3  <= '0;
            dec_funct7  <= '0;
            dec_rd      <= '0;
            dec_imm     <= '0;
            dec_rs1_val <= '0;
            dec_rs2_val <= '0;
        end else if (instr_valid) begin
            dec_pc      <= instr_pc;
            dec_class   <= dec.inst_class;
            dec_opcode  <= dec.opcode;
            dec_funct3  <= dec.funct3;
            dec_funct7  <= dec.funct7;
            dec_rd      <= dec.rd;
            dec_imm     <= dec.imm;
            // Operands already include any forwarded write-back
            dec_rs1_val <= rs1_val;
            dec_rs2_val <= rs2_val;
        end
    end

    // A second valid cycle needs a fresh strobe behind it
    assert property (@(posedge aclk) disable iff (!rst_n)
        (dec_valid && !instr_valid) |=> !dec_valid)
        else $error("dispatch: dec_valid repeated without a strobe");

    assert property (@(posedge aclk) disable iff (!rst_n)
        !$isunknown(dec_valid))
        else $error("dispatch: dec_valid unknown after reset");

endmodule

`resetall

//--- design/rv32i_pkg.sv
// Shared widths, opcode map, instruction word views and class encoding
// for the RV32I decode stage. Imported by every design module.

package rv32i_pkg;

    // Data width and register file geometry
    localparam int xlen   = 32;
    localparam int nreg   = 32;
    localparam int reg_aw = $clog2(nreg);

    // Base opcode map, low two bits are always 11 for 32-bit encodings
    localparam logic [6:0] op_lui      = 7'b0110111;
    localparam logic [6:0] op_auipc    = 7'b0010111;
    localparam logic [6:0] op_jal      = 7'b1101111;
    localparam logic [6:0] op_jalr     = 7'b1100111;
    localparam logic [6:0] op_branch   = 7'b1100011;
    localparam logic [6:0] op_load     = 7'b0000011;
    localparam logic [6:0] op_store    = 7'b0100011;
    localparam logic [6:0] op_imm      = 7'b0010011;
    localparam logic [6:0] op_op       = 7'b0110011;
    localparam logic [6:0] op_misc_mem = 7'b0001111;
    localparam logic [6:0] op_system   = 7'b1110011;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm_11_0;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    // Also carries the B format, with the bits shuffled by the decoder
    typedef struct packed {
        logic [6:0]        imm_11_5;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_4_0;
        logic [6:0]        opcode;
    } s_fmt_t;

    // Also carries the J format
    typedef struct packed {
        logic [19:0]       imm_31_12;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t          r_fmt;
        i_fmt_t          i_fmt;
        s_fmt_t          s_fmt;
        u_fmt_t          u_fmt;
        logic [xlen-1:0] raw;
    } inst_word_t;

    typedef enum logic [2:0] {
        cls_processing = 3'd0,
        cls_auipc      = 3'd1,
        cls_jal        = 3'd2,
        cls_jalr       = 3'd3,
        cls_branching  = 3'd4,
        cls_system     = 3'd5,
        cls_illegal    = 3'd6
    } inst_class_t;

endpackage

//--- design/rv32i_regfile.sv
// 32 x 32 integer register file with two combinational read ports.
// A same-cycle write-back is forwarded to matching reads; x0 is zero.

`timescale 1ns/1ps
`default_nettype none

module rv32i_regfile (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           wb_valid,
    input  logic [rv32i_pkg::reg_aw-1:0]   wb_rd,
    input  logic [rv32i_pkg::xlen-1:0]     wb_data,
    input  logic [rv32i_pkg::reg_aw-1:0]   rs1,
    input  logic [rv32i_pkg::reg_aw-1:0]   rs2,
    output logic [rv32i_pkg::xlen-1:0]     rs1_val,
    output logic [rv32i_pkg::xlen-1:0]     rs2_val
);

    import rv32i_pkg::*;

    // No storage for x0
    logic [xlen-1:0] regs [1:nreg-1];

    function automatic logic [xlen-1:0] read_port(input logic [reg_aw-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_valid && (wb_rd == addr)) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < nreg; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

    // A write-back to x1..x31 lands in storage at the edge it is sampled on
    assert property (@(posedge aclk) disable iff (!rst_n)
        (wb_valid && (wb_rd != '0)) |=> (regs[$past(wb_rd)] == $past(wb_data)))
        else $error("regfile: write-back did not land in storage");

endmodule

`resetall

//--- filelist.f
+incdir+include
design/rv32i_pkg.sv
design/decode_if.sv
design/rv32i_decoder.sv
design/rv32i_regfile.sv
design/rv32i_dispatch.sv
design/rv32i_decode_stage.sv
tb/tb_rv32i_decode_stage.sv

//--- include/rv32i_tb_enc.svh
// Testbench helpers: build instruction words and compute the expected
// class and immediate by plain bit slicing. Include inside a module.

`ifndef RV32I_TB_ENC_SVH
`define RV32I_TB_ENC_SVH

function automatic logic [31:0] enc_word(input logic [6:0] funct7,
                                         input logic [4:0] rs2,
                                         input logic [4:0] rs1,
                                         input logic [2:0] funct3,
                                         input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

function automatic rv32i_pkg::inst_class_t exp_class(input logic [31:0] w);
    if (w[1:0] != 2'b11) begin
        return rv32i_pkg::cls_illegal;
    end
    case (w[6:0])
        rv32i_pkg::op_lui, rv32i_pkg::op_load, rv32i_pkg::op_store,
        rv32i_pkg::op_imm, rv32i_pkg::op_op:      return rv32i_pkg::cls_processing;
        rv32i_pkg::op_auipc:                      return rv32i_pkg::cls_auipc;
        rv32i_pkg::op_jal:                        return rv32i_pkg::cls_jal;
        rv32i_pkg::op_jalr:                       return rv32i_pkg::cls_jalr;
        rv32i_pkg::op_branch:                     return rv32i_pkg::cls_branching;
        rv32i_pkg::op_misc_mem, rv32i_pkg::op_system: return rv32i_pkg::cls_system;
        default:                                  return rv32i_pkg::cls_illegal;
    endcase
endfunction

function automatic logic [31:0] exp_imm(input logic [31:0] w);
    case (w[6:0])
        rv32i_pkg::op_load, rv32i_pkg::op_imm, rv32i_pkg::op_jalr,
        rv32i_pkg::op_system: return {{20{w[31]}}, w[31:20]};
        rv32i_pkg::op_store:  return {{20{w[31]}}, w[31:25], w[11:7]};
        rv32i_pkg::op_branch: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        rv32i_pkg::op_lui, rv32i_pkg::op_auipc: return {w[31:12], 12'b0};
        rv32i_pkg::op_jal:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:              return '0;
    endcase
endfunction

`endif

//--- tb/tb_rv32i_decode_stage.sv
// Testbench for the RV32I decode stage. Random legal and illegal words,
// write-backs and same-cycle forwarding, checked against a shadow register file.

`timescale 1ns/1ps

module tb_rv32i_decode_stage;

    import rv32i_pkg::*;

    `include "rv32i_tb_enc.svh"

    localparam int period          = 40;
    localparam int per_opcode      = 16;
    localparam int n_illegal       = 48;
    localparam int n_rw            = 40;
    localparam int n_fwd           = 16;
    localparam int max_gap         = 3;
    localparam int stim_cycles     = 3 + (11 * per_opcode + n_illegal + 1) * (1 + max_gap)
                                     + n_rw * (3 + max_gap) + n_fwd + 4;
    localparam int watchdog_cycles = stim_cycles + 50;

    typedef struct packed {
        logic [31:0] pc;
        inst_class_t cls;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] due;
    } pkt_t;

    logic        aclk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        dec_valid;
    logic [31:0] dec_pc;
    inst_class_t dec_class;
    logic [6:0]  dec_opcode;
    logic [2:0]  dec_funct3;
    logic [6:0]  dec_funct7;
    logic [4:0]  dec_rd;
    logic [31:0] dec_imm;
    logic [31:0] dec_rs1_val;
    logic [31:0] dec_rs2_val;

    logic [31:0] shadow [0:31];
    logic [31:0] pc;
    pkt_t        exp_q [$];
    pkt_t        cur;
    int          neg_cnt = 0;
    bit          rst_seen = 1'b0;
    bit          any_packet = 1'b0;

    rv32i_decode_stage DUT (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_class   (dec_class),
        .dec_opcode  (dec_opcode),
        .dec_funct3  (dec_funct3),
        .dec_funct7  (dec_funct7),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_rs1_val (dec_rs1_val),
        .dec_rs2_val (dec_rs2_val)
    );

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // x0 reads zero, a same-cycle write-back wins over the stored value
    function automatic logic [31:0] expected_operand(input logic [4:0] r, input logic fwd,
                                                     input logic [4:0] wrd,
                                                     input logic [31:0] wdata);
        if (r == 5'd0) begin
            return 32'd0;
        end
        if (fwd && (wrd == r)) begin
            return wdata;
        end
        return shadow[r];
    endfunction

    task automatic idle_cycle();
        @(posedge aclk);
        instr_valid <= 1'b0;
        wb_valid    <= 1'b0;
    endtask

    task automatic random_gap();
        repeat ($urandom_range(max_gap)) idle_cycle();
    endtask

    task automatic wb_cycle(input logic [4:0] rd, input logic [31:0] data);
        @(posedge aclk);
        instr_valid <= 1'b0;
        wb_valid    <= 1'b1;
        wb_rd       <= rd;
        wb_data     <= data;
        if (rd != 5'd0) begin
            shadow[rd] = data;
        end
    endtask

    // One strobe, with an optional write-back in the same cycle
    task automatic instr_cycle(input logic [31:0] w, input logic fwd, input logic [4:0] rd,
                               input logic [31:0] data);
        pkt_t p;
        @(posedge aclk);
        instr_valid <= 1'b1;
        instr       <= w;
        instr_pc    <= pc;
        wb_valid    <= fwd;
        wb_rd       <= rd;
        wb_data     <= data;
        p.pc      = pc;
        p.cls     = exp_class(w);
        p.opcode  = w[6:0];
        p.funct3  = w[14:12];
        p.funct7  = w[31:25];
        p.rd      = w[11:7];
        p.imm     = exp_imm(w);
        p.rs1_val = expected_operand(w[19:15], fwd, rd, data);
        p.rs2_val = expected_operand(w[24:20], fwd, rd, data);
        // Sampled at the next edge, visible after the one behind it
        p.due     = neg_cnt + 2;
        exp_q.push_back(p);
        if (fwd && (rd != 5'd0)) begin
            shadow[rd] = data;
        end
        pc = pc + 32'd4;
    endtask

    initial begin
        aclk = 1'b0;
        forever #(period / 2) aclk = ~aclk;
    end

    // Pull the expected packet ahead of the edge that checks it
    always @(negedge aclk) begin
        neg_cnt = neg_cnt + 1;
        if (!rst_n) begin
            rst_seen = 1'b1;
        end
        if (rst_n && dec_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("dec_valid was raised with no instruction outstanding");
            end else begin
                cur = exp_q.pop_front();
                any_packet = 1'b1;
                if (cur.due != neg_cnt) begin
                    fail_run($sformatf("mismatch at %0t: dec_valid on cycle %0d, expected %0d",
                                       $time, neg_cnt, cur.due));
                end
            end
        end
    end

    a_idle: assert property (@(posedge aclk) (rst_seen && !any_packet) |->
        ({dec_valid, dec_pc, dec_class, dec_opcode, dec_funct3, dec_funct7, dec_rd,
          dec_imm, dec_rs1_val, dec_rs2_val} == '0))
        else fail_run($sformatf("mismatch at %0t: outputs not zero before first packet", $time));

    a_fields: assert property (@(posedge aclk) disable iff (!rst_n) dec_valid |->
        (dec_class == cur.cls && dec_opcode == cur.opcode && dec_funct3 == cur.funct3 &&
         dec_funct7 == cur.funct7 && dec_rd == cur.rd && dec_pc == cur.pc))
        else fail_run($sformatf("mismatch at %0t: fields at pc %h, class %0d expected %0d",
                                $time, cur.pc, $sampled(dec_class), cur.cls));

    a_imm: assert property (@(posedge aclk) disable iff (!rst_n) dec_valid |->
        (dec_imm == cur.imm))
        else fail_run($sformatf("mismatch at %0t: dec_imm %h expected %h at pc %h",
                                $time, $sampled(dec_imm), cur.imm, cur.pc));

    a_operands: assert property (@(posedge aclk) disable iff (!rst_n) dec_valid |->
        (dec_rs1_val == cur.rs1_val && dec_rs2_val == cur.rs2_val))
        else fail_run($sformatf("mismatch at %0t: operands %h %h expected %h %h", $time,
                                $sampled(dec_rs1_val), $sampled(dec_rs2_val),
                                cur.rs1_val, cur.rs2_val));

    initial begin
        #(watchdog_cycles * period);
        fail_run("timeout: the run did not finish within the expected number of cycles");
    end

    initial begin
        logic [31:0] w;
        logic [4:0]  rd_a;
        logic [4:0]  rd_b;
        logic [6:0]  ops [0:10];
        void'($urandom(32'h7338_8160));
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        rst_n       = 1'b0;
        pc          = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        ops = '{op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store,
                op_imm, op_op, op_misc_mem, op_system};
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;

        foreach (ops[k]) begin
            repeat (per_opcode) begin
                w      = $urandom();
                w[6:0] = ops[k];
                instr_cycle(w, 1'b0, 5'd0, 32'd0);
                random_gap();
            end
        end

        // All-zero word is illegal here
        instr_cycle(32'h0000_0000, 1'b0, 5'd0, 32'd0);
        for (int i = 0; i < n_illegal; i++) begin
            w = $urandom();
            if (i % 2 == 0) begin
                w[1:0] = 2'($urandom_range(2));
            end else begin
                w[1:0] = 2'b11;
                while (exp_class(w) != cls_illegal) begin
                    w[6:2] = 5'($urandom());
                end
            end
            instr_cycle(w, 1'b0, 5'd0, 32'd0);
            random_gap();
        end

        for (int i = 0; i < n_rw; i++) begin
            rd_a = 5'($urandom());
            rd_b = 5'($urandom());
            if (i % 8 == 0) begin
                rd_a = 5'd0;
            end
            wb_cycle(rd_a, $urandom());
            wb_cycle(rd_b, $urandom());
            w = enc_word(7'($urandom()), rd_b, rd_a, 3'($urandom()), 5'($urandom()), op_op);
            instr_cycle(w, 1'b0, 5'd0, 32'd0);
            random_gap();
        end

        // Write-back in the strobe cycle, back to back
        for (int i = 0; i < n_fwd; i++) begin
            rd_a = (i == n_fwd - 1) ? 5'd0 : 5'($urandom_range(31, 1));
            rd_b = 5'($urandom());
            if (i % 2 == 0) begin
                w = enc_word(7'($urandom()), rd_b, rd_a, 3'($urandom()), 5'($urandom()),
                             op_branch);
            end else begin
                w = enc_word(7'($urandom()), rd_a, rd_b, 3'($urandom()), 5'($urandom()),
                             op_branch);
            end
            instr_cycle(w, 1'b1, rd_a, $urandom());
        end

        repeat (4) idle_cycle();
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected packets never appeared on dec_valid",
                               exp_q.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
